// File: csr_pkg.sv
`default_nettype none

package csr_pkg;

    typedef logic [13:0] csr_num_t;
    typedef logic [31:0] word_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [12:0] int_vec_t;
    typedef logic [1:0]  plv_t;

    // Register numbers
    localparam csr_num_t CSR_CRMD   = 14'h000;
    localparam csr_num_t CSR_PRMD   = 14'h001;
    localparam csr_num_t CSR_ECFG   = 14'h004;
    localparam csr_num_t CSR_ESTAT  = 14'h005;
    localparam csr_num_t CSR_ERA    = 14'h006;
    localparam csr_num_t CSR_BADV   = 14'h007;
    localparam csr_num_t CSR_EENTRY = 14'h00c;
    localparam csr_num_t CSR_SAVE0  = 14'h030;
    localparam csr_num_t CSR_SAVE1  = 14'h031;
    localparam csr_num_t CSR_SAVE2  = 14'h032;
    localparam csr_num_t CSR_SAVE3  = 14'h033;
    localparam csr_num_t CSR_TID    = 14'h040;
    localparam csr_num_t CSR_TCFG   = 14'h041;
    localparam csr_num_t CSR_TVAL   = 14'h042;
    localparam csr_num_t CSR_TICLR  = 14'h044;

    // Address error codes
    localparam ecode_t    ECODE_ADE     = 6'h08;
    localparam ecode_t    ECODE_ALE     = 6'h09;
    localparam esubcode_t ESUBCODE_ADEF = 9'd0;

    localparam int_vec_t LIE_MASK   = 13'h1bff;
    localparam word_t    TIMER_IDLE = 32'hffff_ffff;

    // Field positions
    localparam int CRMD_IE_BIT       = 2;
    localparam int CRMD_DA_BIT       = 3;
    localparam int CRMD_WIDTH        = 9;
    localparam int PRMD_IE_BIT       = 2;
    localparam int ESTAT_ECODE_LSB   = 16;
    localparam int ESTAT_ESUB_LSB    = 22;
    localparam int EENTRY_LSB        = 6;
    localparam int TIMER_IRQ_BIT     = 11;
    localparam int TCFG_EN_BIT       = 0;
    localparam int TCFG_PERIODIC_BIT = 1;
    localparam int TCFG_INITVAL_LSB  = 2;
    localparam int TICLR_CLR_BIT     = 0;

    // Bits under a set mask bit take the new value
    function automatic word_t masked_merge(word_t old_val, word_t mask, word_t value);
        return (mask & value) | (~mask & old_val);
    endfunction

endpackage

`default_nettype wire

// File: csr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module csr_ctrl (
    input  wire csr_pkg::csr_num_t csr_num,
    input  wire                    csr_we,
    input  wire csr_pkg::word_t    crmd_rv,
    input  wire csr_pkg::word_t    prmd_rv,
    input  wire csr_pkg::word_t    estat_code_rv,
    input  wire csr_pkg::word_t    era_rv,
    input  wire csr_pkg::word_t    eentry_rv,
    input  wire csr_pkg::word_t    badv_rv,
    input  wire csr_pkg::int_vec_t estat_is,
    input  wire csr_pkg::word_t    ecfg_rv,
    input  wire csr_pkg::word_t    tcfg_rv,
    input  wire csr_pkg::word_t    tval_rv,
    input  wire csr_pkg::word_t    save_rv [4],
    input  wire csr_pkg::word_t    tid_rv,
    output logic                   wr_crmd,
    output logic                   wr_prmd,
    output logic                   wr_ecfg,
    output logic                   wr_estat,
    output logic                   wr_era,
    output logic                   wr_eentry,
    output logic [3:0]             wr_save,
    output logic                   wr_tid,
    output logic                   wr_tcfg,
    output logic                   wr_ticlr,
    output csr_pkg::word_t         csr_rvalue
);
    import csr_pkg::*;

    // One decode drives both the write strobes and the read mux
    always_comb begin
        wr_crmd    = 1'b0;
        wr_prmd    = 1'b0;
        wr_ecfg    = 1'b0;
        wr_estat   = 1'b0;
        wr_era     = 1'b0;
        wr_eentry  = 1'b0;
        wr_save    = 4'b0;
        wr_tid     = 1'b0;
        wr_tcfg    = 1'b0;
        wr_ticlr   = 1'b0;
        csr_rvalue = '0;
        case (csr_num)
            CSR_CRMD: begin
                wr_crmd    = csr_we;
                csr_rvalue = crmd_rv;
            end
            CSR_PRMD: begin
                wr_prmd    = csr_we;
                csr_rvalue = prmd_rv;
            end
            CSR_ECFG: begin
                wr_ecfg    = csr_we;
                csr_rvalue = ecfg_rv;
            end
            CSR_ESTAT: begin
                wr_estat   = csr_we;
                csr_rvalue = estat_code_rv | word_t'(estat_is);
            end
            CSR_ERA: begin
                wr_era     = csr_we;
                csr_rvalue = era_rv;
            end
            CSR_BADV:  csr_rvalue = badv_rv;
            CSR_EENTRY: begin
                wr_eentry  = csr_we;
                csr_rvalue = eentry_rv;
            end
            CSR_SAVE0: begin
                wr_save[0] = csr_we;
                csr_rvalue = save_rv[0];
            end
            CSR_SAVE1: begin
                wr_save[1] = csr_we;
                csr_rvalue = save_rv[1];
            end
            CSR_SAVE2: begin
                wr_save[2] = csr_we;
                csr_rvalue = save_rv[2];
            end
            CSR_SAVE3: begin
                wr_save[3] = csr_we;
                csr_rvalue = save_rv[3];
            end
            CSR_TID: begin
                wr_tid     = csr_we;
                csr_rvalue = tid_rv;
            end
            CSR_TCFG: begin
                wr_tcfg    = csr_we;
                csr_rvalue = tcfg_rv;
            end
            CSR_TVAL:  csr_rvalue = tval_rv;
            // TICLR is write-only, reads zero
            CSR_TICLR: wr_ticlr = csr_we;
            default:   csr_rvalue = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: csr_exc_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csr_exc_regs (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire                     wr_crmd,
    input  wire                     wr_prmd,
    input  wire                     wr_era,
    input  wire                     wr_eentry,
    input  wire csr_pkg::word_t     csr_wmask,
    input  wire csr_pkg::word_t     csr_wvalue,
    input  wire                     wb_ex,
    input  wire                     ertn_flush,
    input  wire csr_pkg::ecode_t    wb_ecode,
    input  wire csr_pkg::esubcode_t wb_esubcode,
    input  wire csr_pkg::word_t     wb_pc,
    input  wire csr_pkg::word_t     wb_vaddr,
    output csr_pkg::word_t          crmd_rv,
    output csr_pkg::word_t          prmd_rv,
    output csr_pkg::word_t          estat_code_rv,
    output csr_pkg::word_t          era_rv,
    output csr_pkg::word_t          eentry_rv,
    output csr_pkg::word_t          badv_rv,
    output csr_pkg::word_t          ex_entry,
    output logic                    crmd_ie
);
    import csr_pkg::*;

    plv_t                            crmd_plv;
    logic [CRMD_WIDTH-1:CRMD_DA_BIT] crmd_mode;
    plv_t                            prmd_pplv;
    logic                            prmd_pie;
    ecode_t                          estat_ecode;
    esubcode_t                       estat_esubcode;
    word_t                           era;
    logic [31:EENTRY_LSB]            eentry_va;
    word_t                           badv;
    word_t                           crmd_next;
    word_t                           prmd_next;
    word_t                           eentry_next;
    logic                            addr_err;

    assign crmd_next   = masked_merge(crmd_rv, csr_wmask, csr_wvalue);
    assign prmd_next   = masked_merge(prmd_rv, csr_wmask, csr_wvalue);
    assign eentry_next = masked_merge(eentry_rv, csr_wmask, csr_wvalue);
    assign addr_err    = (wb_ecode == ECODE_ADE) || (wb_ecode == ECODE_ALE);

    // CRMD: exception entry, then ertn, then software
    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv               <= '0;
            crmd_ie                <= 1'b0;
            crmd_mode              <= '0;
            crmd_mode[CRMD_DA_BIT] <= 1'b1;
        end else if (wb_ex) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr_crmd) begin
            crmd_plv  <= crmd_next[1:0];
            crmd_ie   <= crmd_next[CRMD_IE_BIT];
            crmd_mode <= crmd_next[CRMD_WIDTH-1:CRMD_DA_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ex) begin
            prmd_pplv      <= crmd_plv;
            prmd_pie       <= crmd_ie;
            era            <= wb_pc;
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
        end else begin
            if (wr_prmd) begin
                prmd_pplv <= prmd_next[1:0];
                prmd_pie  <= prmd_next[PRMD_IE_BIT];
            end
            if (wr_era) begin
                era <= masked_merge(era, csr_wmask, csr_wvalue);
            end
        end
    end

    // Fetch errors report the PC itself
    always_ff @(posedge clk) begin
        if (wb_ex && addr_err) begin
            badv <= (wb_ecode == ECODE_ADE && wb_esubcode == ESUBCODE_ADEF) ? wb_pc : wb_vaddr;
        end
        if (wr_eentry) begin
            eentry_va <= eentry_next[31:EENTRY_LSB];
        end
    end

    assign crmd_rv       = {{(32 - CRMD_WIDTH){1'b0}}, crmd_mode, crmd_ie, crmd_plv};
    assign prmd_rv       = {29'b0, prmd_pie, prmd_pplv};
    assign estat_code_rv = (word_t'(estat_ecode) << ESTAT_ECODE_LSB)
                         | (word_t'(estat_esubcode) << ESTAT_ESUB_LSB);
    assign era_rv        = era;
    assign eentry_rv     = {eentry_va, {EENTRY_LSB{1'b0}}};
    assign badv_rv       = badv;
    assign ex_entry      = eentry_rv;

endmodule

`default_nettype wire

// File: csr_int_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csr_int_regs (
    input  wire                 clk,
    input  wire                 resetn,
    input  wire                 wr_estat,
    input  wire                 wr_ecfg,
    input  wire                 wr_ticlr,
    input  wire csr_pkg::word_t csr_wmask,
    input  wire csr_pkg::word_t csr_wvalue,
    input  wire [7:0]           hw_int,
    input  wire                 ipi_int,
    input  wire                 timer_fire,
    input  wire                 crmd_ie,
    output csr_pkg::int_vec_t   estat_is,
    output csr_pkg::word_t      ecfg_rv,
    output logic                has_int
);
    import csr_pkg::*;

    int_vec_t ecfg_lie;
    word_t    estat_next;
    word_t    ecfg_next;
    logic     ticlr_clr;

    assign estat_next = masked_merge(word_t'(estat_is), csr_wmask, csr_wvalue);
    assign ecfg_next  = masked_merge(ecfg_rv, csr_wmask, csr_wvalue);
    assign ticlr_clr  = wr_ticlr && csr_wmask[TICLR_CLR_BIT] && csr_wvalue[TICLR_CLR_BIT];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            estat_is <= '0;
            ecfg_lie <= '0;
        end else begin
            // Software interrupts
            if (wr_estat) begin
                estat_is[1:0] <= estat_next[1:0];
            end
            estat_is[9:2] <= hw_int;
            estat_is[10]  <= 1'b0;
            // Expiry beats a clear in the same cycle
            if (timer_fire) begin
                estat_is[TIMER_IRQ_BIT] <= 1'b1;
            end else if (ticlr_clr) begin
                estat_is[TIMER_IRQ_BIT] <= 1'b0;
            end
            estat_is[12] <= ipi_int;
            if (wr_ecfg) begin
                ecfg_lie <= ecfg_next[12:0] & LIE_MASK;
            end
        end
    end

    assign ecfg_rv = word_t'(ecfg_lie);
    assign has_int = (|(estat_is & ecfg_lie)) && crmd_ie;

endmodule

`default_nettype wire

// File: csr_timer.sv
`timescale 1ns/1ps
`default_nettype none

module csr_timer (
    input  wire                 clk,
    input  wire                 resetn,
    input  wire                 wr_tcfg,
    input  wire csr_pkg::word_t csr_wmask,
    input  wire csr_pkg::word_t csr_wvalue,
    output csr_pkg::word_t      tcfg_rv,
    output csr_pkg::word_t      tval_rv,
    output logic                timer_fire
);
    import csr_pkg::*;

    logic                      tcfg_en;
    logic                      tcfg_periodic;
    logic [31:TCFG_INITVAL_LSB] tcfg_initval;
    word_t                     tcfg_next;
    word_t                     timer_cnt;

    assign tcfg_next = masked_merge(tcfg_rv, csr_wmask, csr_wvalue);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            tcfg_en <= 1'b0;
        end else if (wr_tcfg) begin
            tcfg_en <= tcfg_next[TCFG_EN_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_tcfg) begin
            tcfg_periodic <= tcfg_next[TCFG_PERIODIC_BIT];
            tcfg_initval  <= tcfg_next[31:TCFG_INITVAL_LSB];
        end
    end

    // A one-shot count wraps from zero to idle and stops there
    always_ff @(posedge clk) begin
        if (!resetn) begin
            timer_cnt <= TIMER_IDLE;
        end else if (wr_tcfg && tcfg_next[TCFG_EN_BIT]) begin
            timer_cnt <= {tcfg_next[31:TCFG_INITVAL_LSB], {TCFG_INITVAL_LSB{1'b0}}};
        end else if (tcfg_en && timer_cnt != TIMER_IDLE) begin
            if (timer_cnt == '0 && tcfg_periodic) begin
                timer_cnt <= {tcfg_initval, {TCFG_INITVAL_LSB{1'b0}}};
            end else begin
                timer_cnt <= timer_cnt - 32'd1;
            end
        end
    end

    assign tcfg_rv    = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tval_rv    = timer_cnt;
    assign timer_fire = tcfg_en && (timer_cnt == '0);

endmodule

`default_nettype wire

// File: csr_save_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csr_save_regs (
    input  wire                 clk,
    input  wire                 resetn,
    input  wire [3:0]           wr_save,
    input  wire                 wr_tid,
    input  wire csr_pkg::word_t csr_wmask,
    input  wire csr_pkg::word_t csr_wvalue,
    input  wire csr_pkg::word_t coreid,
    output csr_pkg::word_t      save_rv [4],
    output csr_pkg::word_t      tid_rv
);
    import csr_pkg::*;

    // Scratch words
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (wr_save[i]) begin
                save_rv[i] <= masked_merge(save_rv[i], csr_wmask, csr_wvalue);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            tid_rv <= coreid;
        end else if (wr_tid) begin
            tid_rv <= masked_merge(tid_rv, csr_wmask, csr_wvalue);
        end
    end

endmodule

`default_nettype wire

// File: csr_top.sv
`timescale 1ns/1ps
`default_nettype none

module csr_top (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire csr_pkg::csr_num_t  csr_num,
    input  wire                     csr_we,
    input  wire csr_pkg::word_t     csr_wmask,
    input  wire csr_pkg::word_t     csr_wvalue,
    input  wire                     wb_ex,
    input  wire                     ertn_flush,
    input  wire csr_pkg::ecode_t    wb_ecode,
    input  wire csr_pkg::esubcode_t wb_esubcode,
    input  wire csr_pkg::word_t     wb_pc,
    input  wire csr_pkg::word_t     wb_vaddr,
    input  wire [7:0]               hw_int,
    input  wire                     ipi_int,
    input  wire csr_pkg::word_t     coreid,
    output csr_pkg::word_t          csr_rvalue,
    output csr_pkg::word_t          ex_entry,
    output logic                    has_int
);
    import csr_pkg::*;

    logic       wr_crmd, wr_prmd, wr_ecfg, wr_estat, wr_era, wr_eentry;
    logic [3:0] wr_save;
    logic       wr_tid, wr_tcfg, wr_ticlr;
    word_t      crmd_rv, prmd_rv, estat_code_rv, era_rv, eentry_rv, badv_rv;
    int_vec_t   estat_is;
    word_t      ecfg_rv, tcfg_rv, tval_rv, tid_rv;
    word_t      save_rv [4];
    logic       crmd_ie;
    logic       timer_fire;

    csr_ctrl i_csr_ctrl (
        .csr_num, .csr_we,
        .crmd_rv, .prmd_rv, .estat_code_rv, .era_rv, .eentry_rv, .badv_rv,
        .estat_is, .ecfg_rv, .tcfg_rv, .tval_rv, .save_rv, .tid_rv,
        .wr_crmd, .wr_prmd, .wr_ecfg, .wr_estat, .wr_era, .wr_eentry,
        .wr_save, .wr_tid, .wr_tcfg, .wr_ticlr,
        .csr_rvalue
    );

    csr_exc_regs i_csr_exc_regs (
        .clk, .resetn,
        .wr_crmd, .wr_prmd, .wr_era, .wr_eentry,
        .csr_wmask, .csr_wvalue,
        .wb_ex, .ertn_flush, .wb_ecode, .wb_esubcode, .wb_pc, .wb_vaddr,
        .crmd_rv, .prmd_rv, .estat_code_rv, .era_rv, .eentry_rv, .badv_rv,
        .ex_entry, .crmd_ie
    );

    csr_int_regs i_csr_int_regs (
        .clk, .resetn,
        .wr_estat, .wr_ecfg, .wr_ticlr,
        .csr_wmask, .csr_wvalue,
        .hw_int, .ipi_int, .timer_fire, .crmd_ie,
        .estat_is, .ecfg_rv, .has_int
    );

    csr_timer i_csr_timer (
        .clk, .resetn, .wr_tcfg,
        .csr_wmask, .csr_wvalue,
        .tcfg_rv, .tval_rv, .timer_fire
    );

    csr_save_regs i_csr_save_regs (
        .clk, .resetn, .wr_save, .wr_tid,
        .csr_wmask, .csr_wvalue, .coreid,
        .save_rv, .tid_rv
    );

endmodule

`default_nettype wire

// File: csr_top_properties.sv
`timescale 1ns/1ps
`default_nettype none

module csr_top_properties (
    input wire                    clk,
    input wire                    resetn,
    input wire                    wb_ex,
    input wire                    has_int,
    input wire csr_pkg::word_t    crmd_rv,
    input wire                    timer_fire,
    input wire csr_pkg::int_vec_t estat_is
);
    import csr_pkg::*;

    // Interrupts stay masked while the visible CRMD IE is clear
    no_int_without_ie: assert property (@(posedge clk) disable iff (!resetn)
        !crmd_rv[CRMD_IE_BIT] |-> !has_int)
        else $error("has_int is high while CRMD IE is 0");

    // Exception entry drops to kernel level with interrupts off
    ex_clears_plv_ie: assert property (@(posedge clk) disable iff (!resetn)
        wb_ex |=> (crmd_rv[1:0] == 2'b00) && !crmd_rv[CRMD_IE_BIT])
        else $error("CRMD PLV or IE not cleared after wb_ex");

    timer_sets_irq: assert property (@(posedge clk) disable iff (!resetn)
        timer_fire |=> estat_is[TIMER_IRQ_BIT])
        else $error("ESTAT IS[11] not set one cycle after timer_fire");

endmodule

bind csr_top csr_top_properties i_csr_top_properties (
    .clk, .resetn, .wb_ex, .has_int, .crmd_rv, .timer_fire, .estat_is
);

`default_nettype wire

// File: tb_csr_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csr_top;
    import csr_pkg::*;

    localparam int MAX_CYCLES = 4000;

    logic       clk;
    logic       resetn;
    csr_num_t   csr_num;
    logic       csr_we;
    word_t      csr_wmask;
    word_t      csr_wvalue;
    logic       wb_ex;
    logic       ertn_flush;
    ecode_t     wb_ecode;
    esubcode_t  wb_esubcode;
    word_t      wb_pc;
    word_t      wb_vaddr;
    logic [7:0] hw_int;
    logic       ipi_int;
    word_t      coreid;
    word_t      csr_rvalue;
    word_t      ex_entry;
    logic       has_int;

    // Reference model of the register state
    word_t    m_crmd, m_prmd, m_era, m_badv, m_eentry, m_ecfg, m_estat_code;
    word_t    m_save [4];
    int_vec_t m_is;
    logic     eentry_valid;

    integer seed;
    int     errors;
    int     test_errors;
    int     pass_count;
    int     fail_count;
    int     cycles = 0;
    int     waited;
    int     n;
    word_t  value;
    word_t  pc;
    word_t  vaddr;

    csr_top i_csr_top (
        .clk, .resetn, .csr_num, .csr_we, .csr_wmask, .csr_wvalue,
        .wb_ex, .ertn_flush, .wb_ecode, .wb_esubcode, .wb_pc, .wb_vaddr,
        .hw_int, .ipi_int, .coreid, .csr_rvalue, .ex_entry, .has_int
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run exceeded %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic word_t merge_bits(word_t old_val, word_t mask, word_t val);
        return (val & mask) | (old_val & ~mask);
    endfunction

    function automatic logic expected_has_int();
        return (|(m_is & m_ecfg[12:0])) && m_crmd[CRMD_IE_BIT];
    endfunction

    task automatic check_value(input string name, input word_t exp, input word_t act);
        assert (act === exp) else begin
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_read(input csr_num_t num, input word_t exp, input string name);
        @(negedge clk);
        csr_num = num;
        csr_we  = 1'b0;
        #1;
        check_value({"csr_rvalue ", name}, exp, csr_rvalue);
        check_value("has_int", word_t'(expected_has_int()), word_t'(has_int));
        if (eentry_valid) begin
            check_value("ex_entry", m_eentry, ex_entry);
        end
    endtask

    task automatic write_csr(input csr_num_t num, input word_t mask, input word_t val);
        @(negedge clk);
        csr_num    = num;
        csr_we     = 1'b1;
        csr_wmask  = mask;
        csr_wvalue = val;
        @(negedge clk);
        csr_we = 1'b0;
    endtask

    // First write uses a full mask so the model starts from a known value
    task automatic masked_rw(input csr_num_t num, input word_t keep, input string name,
                             inout word_t model);
        word_t mask;
        word_t val;
        for (int i = 0; i < 3; i++) begin
            mask = (i == 0) ? '1 : $random(seed);
            val  = $random(seed);
            write_csr(num, mask, val);
            model = merge_bits(model, mask, val) & keep;
            check_read(num, model, name);
        end
    endtask

    task automatic take_exception(input ecode_t code, input esubcode_t sub,
                                  input word_t epc, input word_t addr);
        @(negedge clk);
        wb_ex       = 1'b1;
        wb_ecode    = code;
        wb_esubcode = sub;
        wb_pc       = epc;
        wb_vaddr    = addr;
        @(negedge clk);
        wb_ex = 1'b0;
        m_prmd       = m_crmd & 32'h7;
        m_crmd       = m_crmd & ~32'h7;
        m_era        = epc;
        m_estat_code = (word_t'(code) << 16) | (word_t'(sub) << 22);
        if (code == ECODE_ADE || code == ECODE_ALE) begin
            m_badv = (code == ECODE_ADE && sub == ESUBCODE_ADEF) ? epc : addr;
        end
    endtask

    task automatic return_from_exception();
        @(negedge clk);
        ertn_flush = 1'b1;
        @(negedge clk);
        ertn_flush = 1'b0;
        m_crmd = (m_crmd & ~32'h7) | (m_prmd & 32'h7);
    endtask

    // Counts cycles until ESTAT shows the timer interrupt
    task automatic wait_timer_irq(output int count);
        csr_num = CSR_ESTAT;
        count   = 0;
        #1;
        while (!csr_rvalue[TIMER_IRQ_BIT] && count < 200) begin
            @(negedge clk);
            #1;
            count++;
        end
        assert (csr_rvalue[TIMER_IRQ_BIT]) else begin
            $display("Timer interrupt never showed up in ESTAT at %0t", $time);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == test_errors) begin
            pass_count++;
            $display("PASS  %s", name);
        end else begin
            fail_count++;
            $display("FAIL  %s", name);
        end
        test_errors = errors;
    endtask

    initial begin
        seed         = 32'hef69;
        errors       = 0;
        test_errors  = 0;
        pass_count   = 0;
        fail_count   = 0;
        resetn       = 1'b0;
        csr_num      = '0;
        csr_we       = 1'b0;
        csr_wmask    = '0;
        csr_wvalue   = '0;
        wb_ex        = 1'b0;
        ertn_flush   = 1'b0;
        wb_ecode     = '0;
        wb_esubcode  = '0;
        wb_pc        = '0;
        wb_vaddr     = '0;
        hw_int       = '0;
        ipi_int      = 1'b0;
        coreid       = $random(seed);
        eentry_valid = 1'b0;
        m_crmd       = 32'h8;
        m_ecfg       = '0;
        m_is         = '0;
        m_estat_code = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        check_read(CSR_CRMD, 32'h8, "CRMD");
        check_read(CSR_TID, coreid, "TID");
        check_read(CSR_TVAL, TIMER_IDLE, "TVAL");
        check_read(CSR_ECFG, '0, "ECFG");
        finish_test("reset values");

        for (int i = 0; i < 4; i++) begin
            masked_rw(csr_num_t'(CSR_SAVE0 + i), '1, "SAVE", m_save[i]);
        end
        masked_rw(CSR_ERA, '1, "ERA", m_era);
        masked_rw(CSR_EENTRY, ~32'h3f, "EENTRY", m_eentry);
        eentry_valid = 1'b1;
        masked_rw(CSR_ECFG, word_t'(LIE_MASK), "ECFG", m_ecfg);
        masked_rw(CSR_PRMD, 32'h7, "PRMD", m_prmd);
        check_read(14'h180, '0, "unimplemented");
        finish_test("masked writes");

        write_csr(CSR_CRMD, 32'h7, 32'h7);
        m_crmd = merge_bits(m_crmd, 32'h7, 32'h7) & 32'h1ff;
        check_read(CSR_CRMD, m_crmd, "CRMD");
        pc    = $random(seed);
        vaddr = $random(seed);
        take_exception(ECODE_ALE, esubcode_t'($random(seed)), pc, vaddr);
        check_read(CSR_ERA, m_era, "ERA");
        check_read(CSR_BADV, m_badv, "BADV");
        check_read(CSR_ESTAT, m_estat_code | word_t'(m_is), "ESTAT");
        check_read(CSR_CRMD, m_crmd, "CRMD");
        check_read(CSR_PRMD, m_prmd, "PRMD");
        return_from_exception();
        check_read(CSR_CRMD, m_crmd, "CRMD");
        take_exception(ECODE_ADE, ESUBCODE_ADEF, $random(seed), $random(seed));
        check_read(CSR_BADV, m_badv, "BADV");
        return_from_exception();
        // Syscall code leaves BADV alone
        take_exception(6'h0b, '0, $random(seed), $random(seed));
        check_read(CSR_BADV, m_badv, "BADV");
        check_read(CSR_ESTAT, m_estat_code | word_t'(m_is), "ESTAT");
        return_from_exception();
        check_read(CSR_CRMD, m_crmd, "CRMD");
        finish_test("exception entry and ertn");

        n = 2;
        write_csr(CSR_TCFG, '1, word_t'(n << 2) | 32'h1);
        wait_timer_irq(waited);
        check_value("timer delay", word_t'(4 * n + 1), word_t'(waited));
        m_is[TIMER_IRQ_BIT] = 1'b1;
        check_read(CSR_TVAL, TIMER_IDLE, "TVAL");
        check_read(CSR_TCFG, word_t'(n << 2) | 32'h1, "TCFG");
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        m_is[TIMER_IRQ_BIT] = 1'b0;
        check_read(CSR_ESTAT, m_estat_code | word_t'(m_is), "ESTAT");
        finish_test("one-shot timer");

        n = 3;
        write_csr(CSR_TCFG, '1, word_t'(n << 2) | 32'h3);
        wait_timer_irq(waited);
        check_value("timer delay", word_t'(4 * n + 1), word_t'(waited));
        m_is[TIMER_IRQ_BIT] = 1'b1;
        repeat (2) begin
            write_csr(CSR_TICLR, 32'h1, 32'h1);
            m_is[TIMER_IRQ_BIT] = 1'b0;
            wait_timer_irq(waited);
            // The clear write itself spans two cycles of the period
            check_value("timer period", word_t'(4 * n + 1), word_t'(waited + 2));
            m_is[TIMER_IRQ_BIT] = 1'b1;
        end
        write_csr(CSR_TCFG, '1, '0);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        m_is[TIMER_IRQ_BIT] = 1'b0;
        check_read(CSR_ESTAT, m_estat_code | word_t'(m_is), "ESTAT");
        finish_test("periodic timer");

        for (int k = 0; k < 8; k++) begin
            @(negedge clk);
            hw_int    = 8'($random(seed));
            ipi_int   = 1'($random(seed));
            m_is[9:2] = hw_int;
            m_is[12]  = ipi_int;
            check_read(CSR_ESTAT, m_estat_code | word_t'(m_is), "ESTAT");
            value = $random(seed);
            write_csr(CSR_ECFG, '1, value);
            m_ecfg = value & word_t'(LIE_MASK);
            value = $random(seed);
            write_csr(CSR_ESTAT, 32'h3, value);
            m_is[1:0] = value[1:0];
            value = $random(seed);
            write_csr(CSR_CRMD, 32'h4, value);
            m_crmd = merge_bits(m_crmd, 32'h4, value) & 32'h1ff;
            check_read(CSR_CRMD, m_crmd, "CRMD");
            check_read(CSR_ECFG, m_ecfg, "ECFG");
        end
        finish_test("interrupts");

        $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
csr_pkg.sv
csr_ctrl.sv
csr_exc_regs.sv
csr_int_regs.sv
csr_timer.sv
csr_save_regs.sv
csr_top.sv
csr_top_properties.sv
tb_csr_top.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = tb_csr_top
FILELIST = verilog.f
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
